// ==== hdl/sinh_pkg.sv ====
// Shared definitions for the vector sinh datapath
//   Q16.16 fixed-point, length and term-index types
//   Taylor series constants and reciprocal table
//   State encodings of the exponential engine and vector sequencer

`default_nettype none

package sinh_pkg;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Signed Q16.16 value
  typedef logic signed [31:0] fixed_t;

  // Vector length or element index
  typedef logic [15:0] count_t;

  // Series term index, 1 to TERM_COUNT
  typedef logic [4:0] term_idx_t;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  localparam int FRAC_BITS = 16;

  // 1.0 in Q16.16
  localparam fixed_t ONE_FIXED = 32'sh0001_0000;

  // Upper bound on series length
  localparam int TERM_COUNT = 20;

  // Largest input magnitude, 4.0
  // Keeps e^4 and every partial term inside the integer range
  localparam fixed_t X_LIMIT = 32'sh0004_0000;

  // Entry k holds round(65536 / k)
  // Entry 0 never addressed
  localparam fixed_t RECIP_TABLE [0:TERM_COUNT] = '{
    32'sd0,
    32'sd65536, 32'sd32768, 32'sd21845, 32'sd16384, 32'sd13107,
    32'sd10923, 32'sd9362,  32'sd8192,  32'sd7282,  32'sd6554,
    32'sd5958,  32'sd5461,  32'sd5041,  32'sd4681,  32'sd4369,
    32'sd4096,  32'sd3855,  32'sd3641,  32'sd3449,  32'sd3277
  };

  //////////////////////////////////////////////////////////////////////
  // State encodings
  //////////////////////////////////////////////////////////////////////

  // Exponential engine
  typedef enum logic {
    EXP_IDLE,
    EXP_RUN
  } exp_state_t;

  // Vector sequencer
  typedef enum logic [1:0] {
    VEC_IDLE,
    VEC_INPUT,
    VEC_WAIT_RESULT
  } vector_state_t;

endpackage

`default_nettype wire

// ==== hdl/exp_series_unit.sv ====
// Iterative exponential engine
//   Truncated Taylor series, one term per clock
//   Term update: term * x, then * 1/k, each followed by >>> 16
//   Stops on a zero term or after TERM_COUNT terms

`timescale 1ns/1ps
`default_nettype none

module exp_series_unit (
  input  wire              CLK,
  input  wire              RST,
  input  wire              start,
  input  wire sinh_pkg::fixed_t x,
  output logic             done,
  output sinh_pkg::fixed_t result
);

  import sinh_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  exp_state_t state;

  // Current term index, next term to be formed
  term_idx_t term_idx;

  // Latched operand and previous term
  fixed_t x_reg;
  fixed_t term;

  // Full-width products of the two-step update
  logic signed [63:0] prod_x;
  logic signed [63:0] prod_r;
  fixed_t step_x;
  fixed_t next_term;

  // Last term of this series
  logic series_stop;

  //////////////////////////////////////////////////////////////////////
  // Term update
  //////////////////////////////////////////////////////////////////////

  // Step one: multiply by x, back to Q16.16
  assign prod_x = term * x_reg;
  assign step_x = fixed_t'(prod_x >>> FRAC_BITS);

  // Step two: divide by k through the reciprocal table
  assign prod_r    = step_x * RECIP_TABLE[term_idx];
  assign next_term = fixed_t'(prod_r >>> FRAC_BITS);

  // Zero term ends the series early
  assign series_stop = (next_term == '0) ||
                       (term_idx == term_idx_t'(TERM_COUNT));

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= EXP_IDLE;
      term_idx <= '0;
      done     <= 1'b0;
    end else begin
      // Single-cycle pulse
      done <= 1'b0;

      case (state)
        EXP_IDLE: begin
          if (start) begin
            term_idx <= term_idx_t'(1);
            state    <= EXP_RUN;
          end
        end
        EXP_RUN: begin
          if (series_stop) begin
            // Result in accumulator is final next cycle
            done  <= 1'b1;
            state <= EXP_IDLE;
          end else begin
            term_idx <= term_idx + term_idx_t'(1);
          end
        end
        default: begin
          state <= EXP_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Accumulator drives the result port directly
  always_ff @(posedge CLK) begin
    if (state == EXP_IDLE) begin
      if (start) begin
        x_reg  <= x;
        term   <= ONE_FIXED;
        result <= ONE_FIXED;
      end
    end else begin
      term <= next_term;
      // Zero term adds nothing
      if (next_term != '0) begin
        result <= result + next_term;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Launcher must wait for done before restarting
  assert property (@(posedge CLK) disable iff (RST)
    start |-> state != EXP_RUN)
    else $error("exp_series_unit: start while series running");

  // Larger operands overflow the partial terms
  assert property (@(posedge CLK) disable iff (RST)
    start |-> (x <= X_LIMIT) && (x >= -X_LIMIT))
    else $error("exp_series_unit: operand outside +/-4.0");

endmodule

`default_nettype wire

// ==== hdl/scalar_sinh_unit.sv ====
// Scalar hyperbolic sine
//   Two exponential engines side by side, on x and on -x
//   Per-engine done flags and result latches
//   Output is (e^x - e^-x) >>> 1 with a one-cycle ready pulse

`timescale 1ns/1ps
`default_nettype none

module scalar_sinh_unit (
  input  wire              CLK,
  input  wire              RST,
  input  wire              start,
  input  wire sinh_pkg::fixed_t data_in,
  output logic             ready,
  output sinh_pkg::fixed_t data_out
);

  import sinh_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Operand and its negation
  fixed_t x_reg;
  fixed_t neg_x;

  // Engine launch, one cycle after start
  logic launch;

  // Engine outputs
  logic   pos_done;
  logic   neg_done;
  fixed_t pos_result;
  fixed_t neg_result;

  // Completion bookkeeping
  logic   pos_flag;
  logic   neg_flag;
  logic   both_done;
  fixed_t pos_res;
  fixed_t neg_res;

  // e^x - e^-x
  fixed_t diff;

  assign neg_x     = -x_reg;
  assign both_done = pos_flag & neg_flag;
  assign diff      = pos_res - neg_res;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      launch   <= 1'b0;
      pos_flag <= 1'b0;
      neg_flag <= 1'b0;
      ready    <= 1'b0;
    end else begin
      launch <= start;
      ready  <= 1'b0;

      if (launch) begin
        // New operand, forget old completions
        pos_flag <= 1'b0;
        neg_flag <= 1'b0;
      end else if (both_done) begin
        pos_flag <= 1'b0;
        neg_flag <= 1'b0;
        ready    <= 1'b1;
      end else begin
        // Engines may finish in either order or together
        if (pos_done) pos_flag <= 1'b1;
        if (neg_done) neg_flag <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) x_reg <= data_in;
    if (pos_done) pos_res <= pos_result;
    if (neg_done) neg_res <= neg_result;
    // Halve the difference
    if (both_done) data_out <= diff >>> 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Engines
  //////////////////////////////////////////////////////////////////////

  exp_series_unit i_exp_pos (
    .CLK   (CLK),
    .RST   (RST),
    .start (launch),
    .x     (x_reg),
    .done  (pos_done),
    .result(pos_result)
  );

  exp_series_unit i_exp_neg (
    .CLK   (CLK),
    .RST   (RST),
    .start (launch),
    .x     (neg_x),
    .done  (neg_done),
    .result(neg_result)
  );

  // One result per launch, never back to back
  assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("scalar_sinh_unit: ready held for two cycles");

endmodule

`default_nettype wire

// ==== hdl/vector_sinh_function.sv ====
// Vector hyperbolic sine, top level
//   Element sequencer: idle, input, wait_result
//   One scalar sinh operation in flight at a time
//   Per-element output strobe, ready with the last result

`timescale 1ns/1ps
`default_nettype none

module vector_sinh_function (
  input  wire              CLK,
  input  wire              RST,

  // Control
  input  wire              start,
  output logic             ready,
  input  wire              data_in_enable,
  output logic             data_out_enable,

  // Data
  input  wire sinh_pkg::count_t size_in,
  input  wire sinh_pkg::fixed_t data_in,
  output sinh_pkg::fixed_t data_out
);

  import sinh_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  vector_state_t state;

  // Latched length and running element index
  count_t size_reg;
  count_t index;
  count_t index_next;
  logic   last_elem;

  // Scalar unit interface
  logic   scalar_start;
  logic   scalar_ready;
  fixed_t scalar_data_in;
  fixed_t scalar_data_out;

  assign index_next = index + count_t'(1);
  assign last_elem  = (index_next == size_reg);

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= VEC_IDLE;
      size_reg        <= '0;
      index           <= '0;
      scalar_start    <= 1'b0;
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      data_out        <= '0;
    end else begin
      // Pulses default low
      scalar_start    <= 1'b0;
      ready           <= 1'b0;
      data_out_enable <= 1'b0;

      case (state)
        VEC_IDLE: begin
          if (start) begin
            size_reg <= size_in;
            index    <= '0;
            state    <= VEC_INPUT;
          end
        end
        VEC_INPUT: begin
          // One element accepted, then wait for its result
          if (data_in_enable) begin
            scalar_start <= 1'b1;
            state        <= VEC_WAIT_RESULT;
          end
        end
        VEC_WAIT_RESULT: begin
          // Extra data_in_enable pulses dropped here
          if (scalar_ready) begin
            data_out        <= scalar_data_out;
            data_out_enable <= 1'b1;
            if (last_elem) begin
              ready <= 1'b1;
              state <= VEC_IDLE;
            end else begin
              index <= index_next;
              state <= VEC_INPUT;
            end
          end
        end
        default: begin
          state <= VEC_IDLE;
        end
      endcase
    end
  end

  // Operand capture alongside the scalar start
  always_ff @(posedge CLK) begin
    if (state == VEC_INPUT && data_in_enable) begin
      scalar_data_in <= data_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scalar sinh
  //////////////////////////////////////////////////////////////////////

  scalar_sinh_unit i_scalar_sinh (
    .CLK     (CLK),
    .RST     (RST),
    .start   (scalar_start),
    .data_in (scalar_data_in),
    .ready   (scalar_ready),
    .data_out(scalar_data_out)
  );

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Zero length would never complete
  assert property (@(posedge CLK) disable iff (RST)
    (start && state == VEC_IDLE) |-> size_in != '0)
    else $error("vector_sinh_function: start with zero size");

endmodule

`default_nettype wire

// ==== testbench/sinh_ref_model.svh ====
// Bit-exact reference model of the sinh datapath
//   ref_recip: Q16.16 reciprocal of a term index, rounded to nearest
//   ref_exp: truncated Taylor series with early stop
//   ref_sinh: halved difference of e^x and e^-x
//   sinh_close: real-valued sanity bound against $sinh

`ifndef SINH_REF_MODEL_SVH
`define SINH_REF_MODEL_SVH

// round(65536 / k), halves round up
function automatic longint ref_recip(input int k);
  return (longint'(131072) + longint'(k)) / (longint'(2) * longint'(k));
endfunction

// Series starts at 1.0 for both term and sum
function automatic fixed_t ref_exp(input fixed_t x);
  fixed_t acc;
  fixed_t term;
  fixed_t step;
  fixed_t next;
  longint prod;
  int     k;
  bit     stopped;
  acc     = 32'sh0001_0000;
  term    = 32'sh0001_0000;
  stopped = 1'b0;
  k       = 1;
  while (k <= TERM_COUNT && !stopped) begin
    // Multiply by x, back to Q16.16
    prod = longint'(term) * longint'(x);
    step = fixed_t'(prod >>> 16);
    // Divide by k through the rounded reciprocal
    prod = longint'(step) * ref_recip(k);
    next = fixed_t'(prod >>> 16);
    if (next == 0) begin
      stopped = 1'b1;
    end else begin
      acc  = acc + next;
      term = next;
    end
    k = k + 1;
  end
  return acc;
endfunction

// sinh x = (e^x - e^-x) / 2, halving by arithmetic shift
function automatic fixed_t ref_sinh(input fixed_t x);
  fixed_t diff;
  diff = ref_exp(x) - ref_exp(-x);
  return diff >>> 1;
endfunction

// Result within 2^-8 * (1 + |sinh x|) of the real value
function automatic bit sinh_close(input fixed_t x, input fixed_t y);
  real xr;
  real yr;
  real r;
  real err;
  real mag;
  xr  = $itor(x) / 65536.0;
  yr  = $itor(y) / 65536.0;
  r   = $sinh(xr);
  err = (yr > r) ? (yr - r) : (r - yr);
  mag = (r < 0.0) ? -r : r;
  return err <= (1.0 + mag) / 256.0;
endfunction

`endif

// ==== testbench/vector_sinh_tb.sv ====
// Testbench for the vector sinh top level
//   Clock, reset, strobe counters and cycle watchdog
//   Compare tasks for Q16.16 values and strobe counts
//   Directed tests: idle after reset, single elements, random vector,
//   ignored input pulses, reset in the middle of a vector

`timescale 1ns/1ps
`default_nettype none

module vector_sinh_tb;

  import sinh_pkg::*;

  `include "sinh_ref_model.svh"

  localparam int          RESET_CYCLES = 5;
  localparam int unsigned SEED         = 32'h8658_504b;
  // 5 single, 12 random, 3 with extra pulses, 2 cut by reset, 5 after reset
  localparam int          TOTAL_ELEMS  = 27;
  localparam int          CYCLE_LIMIT  = TOTAL_ELEMS * (TERM_COUNT + 6) +
                                         2 * RESET_CYCLES + 300;

  logic   CLK;
  logic   RST;
  logic   start;
  logic   data_in_enable;
  count_t size_in;
  fixed_t data_in;
  logic   ready;
  logic   data_out_enable;
  fixed_t data_out;

  // Strobe counters, never reset
  count_t out_count   = '0;
  count_t ready_count = '0;
  int     cycle_count = 0;

  int unsigned seed_dummy;
  fixed_t      operands [$];
  fixed_t      last_out;

  vector_sinh_function i_dut (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .ready          (ready),
    .data_in_enable (data_in_enable),
    .data_out_enable(data_out_enable),
    .size_in        (size_in),
    .data_in        (data_in),
    .data_out       (data_out)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////

  // Registered strobes sampled like a flop would
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (data_out_enable) out_count <= out_count + count_t'(1);
    if (ready) ready_count <= ready_count + count_t'(1);
  end

  always @(negedge CLK) begin
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: no final result after %0d clock cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "Simulation stopped by the cycle watchdog");
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_fixed(input fixed_t actual, input fixed_t expected,
                             input string what);
    if (actual !== expected) begin
      report_error($sformatf("%s: got %0d, expected %0d", what, actual, expected));
    end
  endtask

  task automatic check_count(input count_t actual, input count_t expected,
                             input string what);
    if (actual !== expected) begin
      report_error($sformatf("%s: got %0d, expected %0d", what, actual, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Drivers, all called on a falling edge
  ////////////////////////////////////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  task automatic hold_reset();
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  endtask

  // Uniform over -4.0 .. +4.0 inclusive
  function automatic fixed_t draw_operand();
    int unsigned r;
    r = $urandom % (2 * int'(X_LIMIT) + 1);
    return fixed_t'(int'(r) - int'(X_LIMIT));
  endfunction

  task automatic begin_vector(input count_t size);
    start   = 1'b1;
    size_in = size;
    @(negedge CLK);
    start = 1'b0;
  endtask

  task automatic send_element(input fixed_t x);
    data_in        = x;
    data_in_enable = 1'b1;
    @(negedge CLK);
    data_in_enable = 1'b0;
  endtask

  // Junk enable, a mid-vector start, another enable
  task automatic pulse_while_busy(input fixed_t junk);
    data_in        = junk;
    data_in_enable = 1'b1;
    @(negedge CLK);
    data_in_enable = 1'b0;
    start          = 1'b1;
    size_in        = count_t'(7);
    @(negedge CLK);
    start          = 1'b0;
    data_in_enable = 1'b1;
    @(negedge CLK);
    data_in_enable = 1'b0;
  endtask

  // Wait for the strobe, then value, bound and ready flag
  task automatic expect_result(input fixed_t x, input logic last);
    while (!data_out_enable) @(negedge CLK);
    last_out = data_out;
    check_fixed(data_out, ref_sinh(x), $sformatf("sinh of %0d", x));
    if (!sinh_close(x, data_out)) begin
      report_error($sformatf("sinh of %0d: %0d is far from the real value", x, data_out));
    end
    check_count(count_t'(ready), count_t'(last), "ready alongside result");
    @(negedge CLK);
  endtask

  // Whole vector from the operand queue, then strobe totals
  task automatic run_vector();
    count_t out_base;
    count_t ready_base;
    count_t size;
    out_base   = out_count;
    ready_base = ready_count;
    size       = count_t'(operands.size());
    begin_vector(size);
    foreach (operands[i]) begin
      send_element(operands[i]);
      expect_result(operands[i], i == operands.size() - 1);
    end
    wait_cycles(3);
    check_count(out_count - out_base, size, "data_out_enable pulses");
    check_count(ready_count - ready_base, count_t'(1), "ready pulses");
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    wait_cycles(10);
    check_count(out_count, '0, "data_out_enable before first start");
    check_count(ready_count, '0, "ready before first start");
  endtask

  task automatic single_element_vectors();
    fixed_t cases [5];
    cases = '{32'sd0, ONE_FIXED, -ONE_FIXED, X_LIMIT, -X_LIMIT};
    foreach (cases[i]) begin
      operands = '{cases[i]};
      run_vector();
      if (cases[i] == 0) check_fixed(last_out, '0, "sinh of zero");
    end
  endtask

  task automatic random_vector();
    operands.delete();
    repeat (12) operands.push_back(draw_operand());
    run_vector();
  endtask

  // Only accepted elements give results
  task automatic ignored_extra_pulses();
    count_t out_base;
    count_t ready_base;
    out_base   = out_count;
    ready_base = ready_count;
    operands.delete();
    repeat (3) operands.push_back(draw_operand());
    begin_vector(count_t'(3));
    foreach (operands[i]) begin
      send_element(operands[i]);
      pulse_while_busy(draw_operand());
      expect_result(operands[i], i == 2);
    end
    wait_cycles(3);
    check_count(out_count - out_base, count_t'(3), "pulses with ignored inputs");
    check_count(ready_count - ready_base, count_t'(1), "ready with ignored inputs");
  endtask

  task automatic reset_mid_vector();
    fixed_t first;
    fixed_t second;
    first  = draw_operand();
    second = draw_operand();
    begin_vector(count_t'(4));
    send_element(first);
    expect_result(first, 1'b0);
    send_element(second);
    // Reset lands while the second result is on the port
    while (!data_out_enable) @(negedge CLK);
    RST = 1'b1;
    #1;
    check_fixed(data_out, '0, "data_out in reset");
    check_count(count_t'(data_out_enable), '0, "data_out_enable in reset");
    check_count(count_t'(ready), '0, "ready in reset");
    hold_reset();
    operands.delete();
    repeat (5) operands.push_back(draw_operand());
    run_vector();
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    RST            = 1'b1;
    start          = 1'b0;
    data_in_enable = 1'b0;
    size_in        = '0;
    data_in        = '0;
    seed_dummy     = $urandom(SEED);
    hold_reset();
    idle_after_reset();
    single_element_vectors();
    random_vector();
    ignored_extra_pulses();
    reset_mid_vector();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+testbench
hdl/sinh_pkg.sv
hdl/exp_series_unit.sv
hdl/scalar_sinh_unit.sv
hdl/vector_sinh_function.sv
testbench/vector_sinh_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the vector sinh testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=vector_sinh_sim

verilator --binary --timing -Wno-fatal \
  --top-module vector_sinh_tb \
  -f sources.f \
  -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
